// ==== uart_cfg.svh ====
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// Memory address and register data width
`define ADDR_W 32

`define CLK_FREQ 50000000
`define BAUD_RATE 3125000
`define RX_OVERSAMPLE 8

`endif

// ==== uart_pkg.sv ====
package uart_pkg;

    // Register selects on the reg_sel port
    typedef enum logic [2:0] {
        general_cfg  = 3'd0,
        tx_src_start = 3'd1,
        tx_src_stop  = 3'd2,
        rx_buf_start = 3'd3,
        rx_buf_end   = 3'd4,
        rx_buf_ptr   = 3'd5
    } reg_addr_e;

    // Bit positions inside general_cfg and the rx_buf_ptr write word
    localparam int tx_en_bit      = 1;
    localparam int rx_en_bit      = 2;
    localparam int tx_done_bit    = 3;
    localparam int rx_full_bit    = 4;
    localparam int rx_ptr_rst_bit = 5;

    // Receive engine FSM
    typedef enum logic [2:0] {
        idle,
        start,
        data,
        stop,
        write
    } rx_state_e;

endpackage

// ==== mem_if.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

// One requester's byte-wide memory access channel
interface mem_if;
    logic               req;
    logic               we;
    logic [`ADDR_W-1:0] addr;
    logic [7:0]         wdata;
    logic [7:0]         rdata;
    logic               ready;

    modport requester (
        output req, we, addr, wdata,
        input  rdata, ready
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output rdata, ready
    );

endinterface

// ==== baud_gen.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module baud_gen (
    input  logic clk,
    input  logic rst,
    output logic tx_tick,
    output logic rx_tick
);

    localparam int tx_div = `CLK_FREQ / `BAUD_RATE;
    localparam int rx_div = tx_div / `RX_OVERSAMPLE;
    localparam int tx_w   = $clog2(tx_div);
    localparam int rx_w   = $clog2(rx_div);

    localparam logic [tx_w-1:0] tx_last = tx_w'(tx_div - 1);
    localparam logic [rx_w-1:0] rx_last = rx_w'(rx_div - 1);

    logic [tx_w-1:0] tx_cnt;
    logic [rx_w-1:0] rx_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_cnt <= '0;
            rx_cnt <= '0;
        end else begin
            tx_cnt <= (tx_cnt == tx_last) ? '0 : tx_cnt + 1'b1;
            rx_cnt <= (rx_cnt == rx_last) ? '0 : rx_cnt + 1'b1;
        end
    end

    assign tx_tick = (tx_cnt == tx_last);
    assign rx_tick = (rx_cnt == rx_last);

endmodule

// ==== uart_tx_dma.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_tx_dma (
    input  logic               clk,
    input  logic               rst,
    input  logic               en,
    input  logic               tick,
    input  logic               ptr_rst,
    input  logic [`ADDR_W-1:0] src_start,
    input  logic [`ADDR_W-1:0] src_stop,
    output logic               done,
    mem_if.requester           mem,
    output logic               tx
);

    typedef enum logic [1:0] {
        tx_idle,
        tx_fetch,
        tx_send
    } tx_state_e;

    tx_state_e          state;
    logic [`ADDR_W-1:0] ptr;
    logic [9:0]         shreg;
    logic [3:0]         bit_cnt;
    logic               last_bit;

    // Stop bit has been on the line for a full bit period
    assign last_bit = (bit_cnt == 4'd10);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= tx_idle;
            ptr     <= '0;
            bit_cnt <= '0;
            tx      <= 1'b1;
        end else begin
            case (state)
                tx_idle: begin
                    if (en && (ptr < src_stop)) begin
                        state <= tx_fetch;
                    end
                end
                tx_fetch: begin
                    if (mem.ready) begin
                        state   <= tx_send;
                        bit_cnt <= '0;
                    end
                end
                tx_send: begin
                    if (tick) begin
                        if (last_bit) begin
                            state <= tx_idle;
                            ptr   <= ptr + 1'b1;
                        end else begin
                            tx      <= shreg[0];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: state <= tx_idle;
            endcase
            if (ptr_rst) begin
                ptr <= src_start;
            end
        end
    end

    // Frame is stop, data LSB first, start; shifted out from bit 0
    always_ff @(posedge clk) begin
        if (state == tx_fetch && mem.ready) begin
            shreg <= {1'b1, mem.rdata, 1'b0};
        end else if (state == tx_send && tick && !last_bit) begin
            shreg <= {1'b1, shreg[9:1]};
        end
    end

    assign done = (ptr == src_stop);

    assign mem.req   = (state == tx_fetch);
    assign mem.we    = 1'b0;
    assign mem.addr  = ptr;
    assign mem.wdata = '0;

endmodule

// ==== uart_rx_dma.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_rx_dma
    import uart_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               en,
    input  logic               tick,
    input  logic               ptr_rst,
    input  logic [`ADDR_W-1:0] buf_start,
    input  logic [`ADDR_W-1:0] buf_end,
    output logic               full,
    output logic [`ADDR_W-1:0] ptr,
    mem_if.requester           mem,
    input  logic               rx
);

    localparam int os_w = $clog2(`RX_OVERSAMPLE);

    localparam logic [os_w-1:0] mid_tick  = os_w'(`RX_OVERSAMPLE / 2 - 1);
    localparam logic [os_w-1:0] last_tick = os_w'(`RX_OVERSAMPLE - 1);

    rx_state_e       state;
    logic            rx_meta;
    logic            rx_sync;
    logic            rx_prev;
    logic [os_w-1:0] os_cnt;
    logic [2:0]      bit_idx;
    logic [7:0]      shreg;
    logic            sample;

    // Middle of the start bit, then one bit period later for every following bit
    assign sample = tick && (os_cnt == ((state == start) ? mid_tick : last_tick));

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idle;
            os_cnt  <= '0;
            bit_idx <= '0;
            ptr     <= '0;
            full    <= 1'b0;
        end else begin
            if (tick) begin
                os_cnt <= sample ? '0 : os_cnt + 1'b1;
            end
            case (state)
                idle: begin
                    os_cnt <= '0;
                    if (en && rx_prev && !rx_sync) begin
                        state <= start;
                    end
                end
                start: begin
                    if (sample) begin
                        // A high line at mid start bit was only a glitch
                        state   <= rx_sync ? idle : data;
                        bit_idx <= '0;
                    end
                end
                data: begin
                    if (sample) begin
                        if (bit_idx == 3'd7) begin
                            state <= stop;
                        end
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                stop: begin
                    if (sample) begin
                        state <= (rx_sync && !full) ? write : idle;
                    end
                end
                write: begin
                    if (mem.ready) begin
                        state <= idle;
                        ptr   <= ptr + 1'b1;
                        if (ptr + 1'b1 == buf_end) begin
                            full <= 1'b1;
                        end
                    end
                end
                default: state <= idle;
            endcase
            if (ptr_rst) begin
                ptr  <= buf_start;
                full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == data && sample) begin
            shreg <= {rx_sync, shreg[7:1]};
        end
    end

    assign mem.req   = (state == write);
    assign mem.we    = 1'b1;
    assign mem.addr  = ptr;
    assign mem.wdata = shreg;

endmodule

// ==== mem_arbiter.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module mem_arbiter (
    input  logic               clk,
    input  logic               rst,
    mem_if.arbiter             tx_bus,
    mem_if.arbiter             rx_bus,
    output logic               mem_req,
    output logic               mem_we,
    output logic [`ADDR_W-1:0] mem_addr,
    output logic [7:0]         mem_wdata,
    input  logic [7:0]         mem_rdata,
    input  logic               mem_ready
);

    typedef enum logic [1:0] {
        grant_none,
        grant_rx,
        grant_tx
    } grant_e;

    grant_e grant;

    // Receive wins a tie, the grant holds until the access completes
    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= grant_none;
        end else begin
            case (grant)
                grant_none: begin
                    if (rx_bus.req) begin
                        grant <= grant_rx;
                    end else if (tx_bus.req) begin
                        grant <= grant_tx;
                    end
                end
                default: begin
                    if (mem_ready) begin
                        grant <= grant_none;
                    end
                end
            endcase
        end
    end

    assign mem_req   = (grant != grant_none);
    assign mem_we    = (grant == grant_rx) ? rx_bus.we : tx_bus.we;
    assign mem_addr  = (grant == grant_rx) ? rx_bus.addr : tx_bus.addr;
    assign mem_wdata = (grant == grant_rx) ? rx_bus.wdata : tx_bus.wdata;

    assign rx_bus.ready = (grant == grant_rx) && mem_ready;
    assign tx_bus.ready = (grant == grant_tx) && mem_ready;
    assign rx_bus.rdata = mem_rdata;
    assign tx_bus.rdata = mem_rdata;

endmodule

// ==== uart_dma.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_dma
    import uart_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               reg_req,
    input  logic               reg_we,
    input  logic [2:0]         reg_sel,
    input  logic [`ADDR_W-1:0] reg_wdata,
    output logic [`ADDR_W-1:0] reg_rdata,
    output logic               reg_ready,
    output logic               mem_req,
    output logic               mem_we,
    output logic [`ADDR_W-1:0] mem_addr,
    output logic [7:0]         mem_wdata,
    input  logic [7:0]         mem_rdata,
    input  logic               mem_ready,
    input  logic               rx,
    output logic               tx
);

    logic               tx_en;
    logic               rx_en;
    logic [`ADDR_W-1:0] tx_start_reg;
    logic [`ADDR_W-1:0] tx_stop_reg;
    logic [`ADDR_W-1:0] rx_start_reg;
    logic [`ADDR_W-1:0] rx_end_reg;
    logic [`ADDR_W-1:0] rx_ptr;
    logic [`ADDR_W-1:0] cfg_word;
    logic               tx_done;
    logic               rx_full;
    logic               tx_ptr_rst;
    logic               rx_ptr_rst;
    logic               tx_tick;
    logic               rx_tick;

    mem_if tx_bus ();
    mem_if rx_bus ();

    always_comb begin
        cfg_word              = '0;
        cfg_word[tx_en_bit]   = tx_en;
        cfg_word[rx_en_bit]   = rx_en;
        cfg_word[tx_done_bit] = tx_done;
        cfg_word[rx_full_bit] = rx_full;
    end

    assign rx_ptr_rst = reg_req && reg_we && (reg_sel == rx_buf_ptr) &&
                        reg_wdata[rx_ptr_rst_bit];

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_en        <= 1'b0;
            rx_en        <= 1'b0;
            tx_start_reg <= '0;
            tx_stop_reg  <= '0;
            rx_start_reg <= '0;
            rx_end_reg   <= '0;
            reg_rdata    <= '0;
            reg_ready    <= 1'b0;
            tx_ptr_rst   <= 1'b0;
        end else begin
            reg_ready  <= reg_req;
            // One cycle late so the engine loads the start value just written
            tx_ptr_rst <= reg_req && reg_we && (reg_sel == tx_src_start);
            if (reg_req) begin
                case (reg_addr_e'(reg_sel))
                    general_cfg: begin
                        reg_rdata <= cfg_word;
                        if (reg_we) begin
                            tx_en <= reg_wdata[tx_en_bit];
                            rx_en <= reg_wdata[rx_en_bit];
                        end
                    end
                    tx_src_start: begin
                        reg_rdata <= tx_start_reg;
                        if (reg_we) begin
                            tx_start_reg <= reg_wdata;
                        end
                    end
                    tx_src_stop: begin
                        reg_rdata <= tx_stop_reg;
                        if (reg_we) begin
                            tx_stop_reg <= reg_wdata;
                        end
                    end
                    rx_buf_start: begin
                        reg_rdata <= rx_start_reg;
                        if (reg_we) begin
                            rx_start_reg <= reg_wdata;
                        end
                    end
                    rx_buf_end: begin
                        reg_rdata <= rx_end_reg;
                        if (reg_we) begin
                            rx_end_reg <= reg_wdata;
                        end
                    end
                    rx_buf_ptr: reg_rdata <= rx_ptr;
                    default:    reg_rdata <= '0;
                endcase
            end
        end
    end

    baud_gen u_baud (
        .clk     (clk),
        .rst     (rst),
        .tx_tick (tx_tick),
        .rx_tick (rx_tick)
    );

    uart_tx_dma u_tx (
        .clk       (clk),
        .rst       (rst),
        .en        (tx_en),
        .tick      (tx_tick),
        .ptr_rst   (tx_ptr_rst),
        .src_start (tx_start_reg),
        .src_stop  (tx_stop_reg),
        .done      (tx_done),
        .mem       (tx_bus),
        .tx        (tx)
    );

    uart_rx_dma u_rx (
        .clk       (clk),
        .rst       (rst),
        .en        (rx_en),
        .tick      (rx_tick),
        .ptr_rst   (rx_ptr_rst),
        .buf_start (rx_start_reg),
        .buf_end   (rx_end_reg),
        .full      (rx_full),
        .ptr       (rx_ptr),
        .mem       (rx_bus),
        .rx        (rx)
    );

    mem_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .tx_bus    (tx_bus),
        .rx_bus    (rx_bus),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

endmodule

// ==== uart_dma_assertions.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_dma_assertions
    import uart_pkg::*;
(
    input logic               clk,
    input logic               rst,
    input logic               reg_req,
    input logic               reg_ready,
    input logic               mem_req,
    input logic               mem_we,
    input logic [`ADDR_W-1:0] mem_addr,
    input logic [7:0]         mem_wdata,
    input logic               mem_ready,
    input rx_state_e          rx_state
);

    int fail_count = 0;

    // Request and its payload hold until the ready pulse
    req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ready |=> mem_req && $stable(mem_addr) &&
                                  $stable(mem_we) && $stable(mem_wdata))
        else begin
            $error("memory request dropped or changed before ready");
            fail_count++;
        end

    no_stray_ready: assert property (@(posedge clk) disable iff (rst)
        mem_ready |-> mem_req)
        else begin
            $error("memory ready without a request");
            fail_count++;
        end

    reg_ready_next: assert property (@(posedge clk) disable iff (rst)
        reg_req |=> reg_ready)
        else begin
            $error("register ready missing one cycle after request");
            fail_count++;
        end

    reg_ready_only: assert property (@(posedge clk) disable iff (rst)
        reg_ready |-> $past(reg_req))
        else begin
            $error("register ready without a request in the cycle before");
            fail_count++;
        end

    // An external write belongs to a received byte waiting in the write state
    rx_write_owner: assert property (@(posedge clk) disable iff (rst)
        mem_req && mem_we |-> rx_state == write)
        else begin
            $error("memory write issued while the receive FSM is not in write state");
            fail_count++;
        end

endmodule

bind uart_dma uart_dma_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .reg_req   (reg_req),
    .reg_ready (reg_ready),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ready (mem_ready),
    .rx_state  (u_rx.state)
);

// ==== tb_uart_dma.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module tb_uart_dma
    import uart_pkg::*;
();

    localparam int bit_clks   = `CLK_FREQ / `BAUD_RATE;
    localparam int wait_limit = 4000;

    logic               clk;
    logic               rst;
    logic               reg_req;
    logic               reg_we;
    logic [2:0]         reg_sel;
    logic [`ADDR_W-1:0] reg_wdata;
    logic [`ADDR_W-1:0] reg_rdata;
    logic               reg_ready;
    logic               mem_req;
    logic               mem_we;
    logic [`ADDR_W-1:0] mem_addr;
    logic [7:0]         mem_wdata;
    logic [7:0]         mem_rdata;
    logic               mem_ready;
    logic               rx;
    logic               tx;

    logic [7:0] mem [0:255];
    int         delays [0:255];
    int         delay_idx;
    int         errors;
    int         assert_fails;
    logic [7:0] tx_exp [$];
    logic [7:0] rx_exp [$];

    uart_dma u_dut (
        .clk       (clk),
        .rst       (rst),
        .reg_req   (reg_req),
        .reg_we    (reg_we),
        .reg_sel   (reg_sel),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .reg_ready (reg_ready),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .rx        (rx),
        .tx        (tx)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Byte-wide memory that answers each access with one ready pulse after a table-driven delay
    initial begin
        logic [7:0] addr;
        logic       we;
        logic [7:0] wdata;
        delay_idx = 0;
        forever begin
            @(negedge clk);
            if (mem_req) begin
                addr  = mem_addr[7:0];
                we    = mem_we;
                wdata = mem_wdata;
                repeat (delays[delay_idx]) @(negedge clk);
                delay_idx = (delay_idx + 1) % 256;
                @(posedge clk);
                if (we) begin
                    mem[addr] = wdata;
                end
                mem_rdata <= mem[addr];
                mem_ready <= 1'b1;
                @(posedge clk);
                mem_ready <= 1'b0;
            end
        end
    end

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        assert (got == exp) else begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input logic [`ADDR_W-1:0] got, input logic [`ADDR_W-1:0] exp,
                              input string what);
        assert (got == exp) else begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic reg_access(input logic we, input reg_addr_e sel,
                              input logic [`ADDR_W-1:0] wdata,
                              output logic [`ADDR_W-1:0] rdata);
        int n;
        @(posedge clk);
        reg_req   <= 1'b1;
        reg_we    <= we;
        reg_sel   <= sel;
        reg_wdata <= wdata;
        @(posedge clk);
        reg_req <= 1'b0;
        reg_we  <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!reg_ready && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (!reg_ready) begin
            errors++;
            $display("register access to select %0d got no ready", sel);
        end
        rdata = reg_rdata;
    endtask

    task automatic reg_write(input reg_addr_e sel, input logic [`ADDR_W-1:0] wdata);
        logic [`ADDR_W-1:0] unused;
        reg_access(1'b1, sel, wdata, unused);
    endtask

    task automatic check_reg(input reg_addr_e sel, input logic [`ADDR_W-1:0] mask,
                             input logic [`ADDR_W-1:0] exp);
        logic [`ADDR_W-1:0] got;
        reg_access(1'b0, sel, '0, got);
        assert ((got & mask) == exp) else begin
            errors++;
            $display("mismatch at %0t: register %0d reads %h, expected %h under mask %h",
                     $time, sel, got, exp, mask);
        end
    endtask

    task automatic wait_reg(input reg_addr_e sel, input logic [`ADDR_W-1:0] mask,
                            input logic [`ADDR_W-1:0] value, input string what);
        logic [`ADDR_W-1:0] got;
        int n;
        n = 0;
        reg_access(1'b0, sel, '0, got);
        while (((got & mask) != value) && n < 200) begin
            reg_access(1'b0, sel, '0, got);
            n++;
        end
        if ((got & mask) != value) begin
            errors++;
            $display("timed out waiting for %s", what);
        end
    endtask

    // Serial monitor on tx that samples each bit in its middle
    task automatic recv_frame(output logic [7:0] data);
        int n;
        n = 0;
        data = '0;
        @(negedge clk);
        while (tx && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (tx) begin
            errors++;
            $display("no start bit appeared on tx");
        end else begin
            repeat (bit_clks / 2) @(negedge clk);
            for (int i = 0; i < 8; i++) begin
                repeat (bit_clks) @(negedge clk);
                data[i] = tx;
            end
            repeat (bit_clks) @(negedge clk);
            assert (tx) else begin
                errors++;
                $display("mismatch at %0t: tx stop bit is low", $time);
            end
        end
    endtask

    // 8N1 frame on rx followed by two idle bit periods
    task automatic send_frame(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= frame[i];
            repeat (bit_clks - 1) @(posedge clk);
        end
        repeat (2 * bit_clks) @(posedge clk);
    endtask

    task automatic prog_tx(input int base, input int len);
        tx_exp.delete();
        for (int i = 0; i < len; i++) begin
            tx_exp.push_back(8'($urandom));
            mem[base + i] = tx_exp[i];
        end
        reg_write(tx_src_start, base);
        reg_write(tx_src_stop, base + len);
    endtask

    task automatic prog_rx(input int start, input int stop, input int len);
        rx_exp.delete();
        for (int i = 0; i < len; i++) begin
            rx_exp.push_back(8'($urandom));
        end
        reg_write(rx_buf_start, start);
        reg_write(rx_buf_end, stop);
        reg_write(rx_buf_ptr, 32'(1) << rx_ptr_rst_bit);
    endtask

    task automatic expect_tx();
        logic [7:0] got;
        for (int i = 0; i < tx_exp.size(); i++) begin
            recv_frame(got);
            check_byte(got, tx_exp[i], "transmitted byte");
        end
    endtask

    task automatic send_rx();
        for (int i = 0; i < rx_exp.size(); i++) begin
            send_frame(rx_exp[i]);
        end
    endtask

    task automatic check_rx_mem(input int start, input int n);
        for (int i = 0; i < n; i++) begin
            check_byte(mem[start + i], rx_exp[i], "received byte in memory");
        end
    endtask

    task automatic test_registers();
        logic [`ADDR_W-1:0] val;
        logic [`ADDR_W-1:0] old;
        // Transmit pointer and stop both reset to 0, so tx_done reads set
        check_reg(general_cfg, '1, 32'(1) << tx_done_bit);
        for (int s = 1; s <= 5; s++) begin
            check_reg(reg_addr_e'(s), '1, '0);
        end
        for (int s = 1; s <= 4; s++) begin
            val = $urandom;
            reg_access(1'b1, reg_addr_e'(s), val, old);
            check_word(old, '0, "value returned during the first write");
            check_reg(reg_addr_e'(s), '1, val);
            reg_access(1'b1, reg_addr_e'(s), ~val, old);
            check_word(old, val, "value returned during the second write");
            check_reg(reg_addr_e'(s), '1, ~val);
        end
    endtask

    task automatic test_transmit();
        prog_tx(8'h10, 4);
        reg_write(general_cfg, 32'(1) << tx_en_bit);
        expect_tx();
        wait_reg(general_cfg, 32'(1) << tx_done_bit, 32'(1) << tx_done_bit, "tx_done");
        reg_write(general_cfg, '0);
    endtask

    task automatic test_receive();
        prog_rx(8'h40, 8'h50, 3);
        reg_write(general_cfg, 32'(1) << rx_en_bit);
        send_rx();
        wait_reg(rx_buf_ptr, '1, 8'h43, "receive pointer to reach buffer start plus 3");
        check_rx_mem(8'h40, 3);
        reg_write(general_cfg, '0);
    endtask

    task automatic test_full();
        logic [7:0] marker;
        marker = mem[8'h62];
        prog_rx(8'h60, 8'h62, 3);
        reg_write(general_cfg, 32'(1) << rx_en_bit);
        send_rx();
        wait_reg(general_cfg, 32'(1) << rx_full_bit, 32'(1) << rx_full_bit, "full flag");
        check_reg(rx_buf_ptr, '1, 8'h62);
        check_rx_mem(8'h60, 2);
        check_byte(mem[8'h62], marker, "byte past buffer end");
        reg_write(rx_buf_ptr, 32'(1) << rx_ptr_rst_bit);
        check_reg(general_cfg, 32'(1) << rx_full_bit, '0);
        check_reg(rx_buf_ptr, '1, 8'h60);
        reg_write(general_cfg, '0);
    endtask

    task automatic test_concurrent();
        prog_tx(8'h80, 4);
        prog_rx(8'ha0, 8'hb0, 3);
        reg_write(general_cfg, (32'(1) << tx_en_bit) | (32'(1) << rx_en_bit));
        fork
            expect_tx();
            send_rx();
        join
        wait_reg(rx_buf_ptr, '1, 8'ha3, "receive pointer during concurrent run");
        wait_reg(general_cfg, 32'(1) << tx_done_bit, 32'(1) << tx_done_bit, "tx_done");
        check_rx_mem(8'ha0, 3);
        reg_write(general_cfg, '0);
    endtask

    initial begin
        errors = 0;
        void'($urandom(32'hcc17));
        for (int i = 0; i < 256; i++) begin
            delays[i] = $urandom_range(5, 0);
            mem[i]    = 8'(i) ^ 8'h3c;
        end
        rst       = 1'b1;
        reg_req   = 1'b0;
        reg_we    = 1'b0;
        reg_sel   = '0;
        reg_wdata = '0;
        mem_rdata = '0;
        mem_ready = 1'b0;
        rx        = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        test_registers();
        test_transmit();
        test_receive();
        test_full();
        test_concurrent();

        assert_fails = u_dut.u_assertions.fail_count;
        $display("Run finished with %0d check errors and %0d assertion failures",
                 errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
uart_pkg.sv
mem_if.sv
baud_gen.sv
uart_tx_dma.sv
uart_rx_dma.sv
mem_arbiter.sv
uart_dma.sv
uart_dma_assertions.sv
tb_uart_dma.sv
